// File: list.f
uart_pkg.sv
uart_tx.sv
uart_rx.sv
tx_fetch.sv
rx_store.sv
wb_arbiter.sv
msg_ram.sv
uart_msg_top.sv
uart_msg_checker.sv
uart_msg_monitor.sv
tb_uart_msg.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_uart_msg -f list.f -o sim_uart_msg
./obj_dir/sim_uart_msg +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

// File: tb_uart_msg.sv
module tb_uart_msg;
  import uart_pkg::*;

  localparam int CPB     = 4;
  localparam int RX_BASE = 128;
  localparam int ROWS    = 4;
  localparam int TIMEOUT = 20000;

  // Message length and host reads during transmit
  typedef struct packed {
    logic [7:0] len;
    logic       rd_busy;
  } row_t;

  row_t rows [ROWS] = '{'{8'd4, 1'b0}, '{8'd12, 1'b1}, '{8'd1, 1'b0}, '{8'd30, 1'b1}};

  logic       clk;
  logic       rst_n;
  wb_req_t    host_req;
  wb_rsp_t    host_rsp;
  logic       start;
  logic [7:0] tx_len;
  logic       tx_busy;
  logic       serial;
  logic [7:0] rx_count;
  logic       exp_push;
  logic [7:0] exp_byte;
  int         mon_errors;
  int         frames;
  int         errors;
  int         seed;

  // Serial loopback, transmitter feeds receiver
  uart_msg_top #(.CYCLES_PER_BIT(CPB), .RX_BASE(RX_BASE)) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_wb       (host_req),
    .o_wb       (host_rsp),
    .i_start    (start),
    .i_tx_len   (tx_len),
    .o_tx_busy  (tx_busy),
    .o_serial   (serial),
    .i_serial   (serial),
    .o_rx_count (rx_count)
  );

  uart_msg_monitor #(.CYCLES_PER_BIT(CPB), .RX_BASE(RX_BASE)) u_monitor (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_serial   (serial),
    .i_start    (start),
    .i_host_req (host_req),
    .i_host_rsp (host_rsp),
    .i_exp_push (exp_push),
    .i_exp_byte (exp_byte),
    .o_errors   (mon_errors),
    .o_frames   (frames)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // One host transfer, held until ack, then bus released for a cycle
  task automatic host_access(input logic we, input logic [7:0] adr, input logic [7:0] wdat);
    int t;
    t = 0;
    host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    do begin
      @(posedge clk);
      t++;
    end while (!host_rsp.ack && t < TIMEOUT);
    if (!host_rsp.ack) begin
      $display("Host transfer to address %0d was never acknowledged", adr);
      errors++;
    end
    host_req <= '0;
    @(posedge clk);
  endtask

  task automatic wait_tx_busy(input logic level);
    int t;
    t = 0;
    while (tx_busy !== level && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (tx_busy !== level) begin
      $display("Timed out waiting for o_tx_busy to become %0b", level);
      errors++;
    end
  endtask

  task automatic wait_rx_count(input logic [7:0] count);
    int t;
    t = 0;
    while (rx_count !== count && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (rx_count !== count) begin
      $display("Timed out waiting for o_rx_count to reach %0d, it is %0d", count, rx_count);
      errors++;
    end
  endtask

  initial begin
    int         r;
    int         i;
    int         n;
    int         len;
    int         total;
    int         asserts;
    logic [7:0] data;
    rst_n    = 1'b0;
    host_req = '0;
    start    = 1'b0;
    tx_len   = 8'd0;
    exp_push = 1'b0;
    exp_byte = 8'd0;
    errors   = 0;
    total    = 0;
    seed     = 52;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // Write then read back, monitor compares
    for (i = 0; i < 4; i++) begin
      data = 8'($random(seed));
      host_access(1'b1, 8'(i * 17), data);
      host_access(1'b0, 8'(i * 17), 8'd0);
    end
    for (r = 0; r < ROWS; r++) begin
      len = int'(rows[r].len);
      total += len;
      // Message bytes, also queued as expected frames
      for (i = 0; i < len; i++) begin
        data = 8'($random(seed));
        exp_push <= 1'b1;
        exp_byte <= data;
        @(posedge clk);
        exp_push <= 1'b0;
        host_access(1'b1, 8'(i), data);
      end
      tx_len <= rows[r].len;
      start  <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      wait_tx_busy(1'b1);
      // Extra start while busy, before any byte is received
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      if (rows[r].rd_busy) begin
        n = 0;
        while (tx_busy && n < TIMEOUT) begin
          host_access(1'b0, 8'(n % len), 8'd0);
          n++;
        end
      end
      wait_tx_busy(1'b0);
      wait_rx_count(rows[r].len);
      for (i = 0; i < len; i++) begin
        host_access(1'b0, 8'(RX_BASE + i), 8'd0);
      end
    end
    if (frames != total) begin
      $display("Fail at %0t: %0d frames decoded, expected %0d", $time, frames, total);
      errors++;
    end
    asserts = DUT.u_checker.ack_fails + DUT.u_checker.grant_fails + DUT.u_checker.reset_fails;
    $display("Errors: testbench %0d, monitor %0d, assertions %0d", errors, mon_errors, asserts);
    if (errors + mon_errors + asserts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: uart_msg_monitor.sv
module uart_msg_monitor #(
  parameter int CYCLES_PER_BIT = 4,
  parameter int RX_BASE        = 128
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_serial,
  input  logic              i_start,
  input  uart_pkg::wb_req_t i_host_req,
  input  uart_pkg::wb_rsp_t i_host_rsp,
  input  logic              i_exp_push,
  input  logic [7:0]        i_exp_byte,
  output int                o_errors,
  output int                o_frames
);
  import uart_pkg::*;

  // Mid-bit sample point and shortest idle run after a stop sample
  localparam int HALF    = CYCLES_PER_BIT / 2;
  localparam int MIN_GAP = 7 * CYCLES_PER_BIT + HALF;

  logic [7:0] exp_q [$];
  logic [7:0] shadow [256];
  logic [9:0] bits;
  logic [7:0] want;
  logic       in_frame;
  int         pos;
  int         gap;
  int         rx_idx;

  always @(posedge clk) begin
    if (!rst_n) begin
      in_frame = 1'b0;
      pos      = 0;
      gap      = 0;
      rx_idx   = 0;
      o_errors = 0;
      o_frames = 0;
    end else begin
      if (i_exp_push) begin
        exp_q.push_back(i_exp_byte);
      end
      // Store restarts at the base of the receive region
      if (i_start) begin
        rx_idx = 0;
      end
      // Host writes feed the memory model
      if (i_host_rsp.ack && i_host_req.we) begin
        shadow[i_host_req.adr] = i_host_req.dat;
      end else if (i_host_rsp.ack && i_host_rsp.dat !== shadow[i_host_req.adr]) begin
        $display("Fail at %0t: host read of address %0d gave %h, expected %h",
                 $time, i_host_req.adr, i_host_rsp.dat, shadow[i_host_req.adr]);
        o_errors++;
      end
      if (!in_frame) begin
        gap++;
        if (!i_serial) begin
          // Falling edge, start of a frame
          if (o_frames > 0 && gap < MIN_GAP) begin
            $display("Fail at %0t: only %0d idle cycles before frame %0d",
                     $time, gap, o_frames);
            o_errors++;
          end
          in_frame = 1'b1;
          pos      = 0;
        end
      end else begin
        pos++;
      end
      // Start, data LSB first, stop
      if (in_frame && pos % CYCLES_PER_BIT == HALF) begin
        bits = {i_serial, bits[9:1]};
        if (pos / CYCLES_PER_BIT == 9) begin
          in_frame = 1'b0;
          gap      = 0;
          if (bits[0] || !bits[9]) begin
            $display("Fail at %0t: frame %0d has start %b and stop %b",
                     $time, o_frames, bits[0], bits[9]);
            o_errors++;
          end
          if (exp_q.size() == 0) begin
            $display("Frame %0d arrived with no byte left to expect", o_frames);
            o_errors++;
          end else begin
            want = exp_q.pop_front();
            if (bits[8:1] !== want) begin
              $display("Fail at %0t: frame %0d carried %h, expected %h",
                       $time, o_frames, bits[8:1], want);
              o_errors++;
            end
            // Loopback, so the store puts this byte at base plus count
            shadow[8'(RX_BASE + rx_idx)] = want;
            rx_idx = (rx_idx + 1) % 128;
          end
          o_frames++;
        end
      end
    end
  end

endmodule

// File: uart_msg_checker.sv
module uart_msg_checker (
  input logic              clk,
  input logic              rst_n,
  input uart_pkg::wb_req_t i_host_req,
  input uart_pkg::wb_rsp_t i_host_rsp,
  input uart_pkg::wb_req_t i_rx_req,
  input uart_pkg::wb_rsp_t i_rx_rsp,
  input uart_pkg::wb_req_t i_tx_req,
  input uart_pkg::wb_rsp_t i_tx_rsp,
  input logic              i_serial,
  input logic              i_tx_busy,
  input logic [7:0]        i_rx_count
);
  import uart_pkg::*;

  int         ack_fails = 0;
  int         grant_fails = 0;
  int         reset_fails = 0;
  logic [2:0] acks;
  logic [2:0] reqs;

  assign acks = {i_rx_rsp.ack, i_tx_rsp.ack, i_host_rsp.ack};
  assign reqs = {i_rx_req.cyc && i_rx_req.stb,
                 i_tx_req.cyc && i_tx_req.stb,
                 i_host_req.cyc && i_host_req.stb};

  // Ack only inside an open cycle
  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n) (acks & ~reqs) == 3'b000)
    else begin
      $error("Wishbone ack without cyc and stb");
      ack_fails++;
    end

  // Single owner gets the ack
  single_ack: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(acks))
    else begin
      $error("More than one master acknowledged");
      grant_fails++;
    end

  // Quiet outputs right after reset
  reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> i_serial && !i_tx_busy && i_rx_count == 8'd0)
    else begin
      $error("Outputs not idle after reset");
      reset_fails++;
    end

endmodule

bind uart_msg_top uart_msg_checker u_checker (
  .clk        (clk),
  .rst_n      (rst_n),
  .i_host_req (i_wb),
  .i_host_rsp (o_wb),
  .i_rx_req   (rx_wb_req),
  .i_rx_rsp   (rx_wb_rsp),
  .i_tx_req   (tx_wb_req),
  .i_tx_rsp   (tx_wb_rsp),
  .i_serial   (o_serial),
  .i_tx_busy  (o_tx_busy),
  .i_rx_count (o_rx_count)
);

// File: uart_msg_top.sv
module uart_msg_top #(
  parameter int CYCLES_PER_BIT = 4,
  parameter int RX_BASE        = 128
) (
  input  logic              clk,
  input  logic              rst_n,
  input  uart_pkg::wb_req_t i_wb,
  output uart_pkg::wb_rsp_t o_wb,
  input  logic              i_start,
  input  logic [7:0]        i_tx_len,
  output logic              o_tx_busy,
  output logic              o_serial,
  input  logic              i_serial,
  output logic [7:0]        o_rx_count
);
  import uart_pkg::*;

  // Bus links between masters, arbiter and memory
  wb_req_t rx_wb_req;
  wb_req_t tx_wb_req;
  wb_req_t ram_wb_req;
  wb_rsp_t rx_wb_rsp;
  wb_rsp_t tx_wb_rsp;
  wb_rsp_t ram_wb_rsp;

  // Fetch to transmitter handshake
  logic [7:0] tx_byte;
  logic       tx_byte_req;
  logic       tx_cts;
  logic       tx_idle;

  // Receiver to store
  logic [7:0] rx_byte;
  logic       rx_byte_valid;

  msg_ram u_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .i_wb  (ram_wb_req),
    .o_wb  (ram_wb_rsp)
  );

  wb_arbiter u_arb (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_rx    (rx_wb_req),
    .i_tx    (tx_wb_req),
    .i_host  (i_wb),
    .i_slave (ram_wb_rsp),
    .o_rx    (rx_wb_rsp),
    .o_tx    (tx_wb_rsp),
    .o_host  (o_wb),
    .o_slave (ram_wb_req)
  );

  tx_fetch u_fetch (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_start (i_start),
    .i_len   (i_tx_len),
    .i_wb    (tx_wb_rsp),
    .i_cts   (tx_cts),
    .i_idle  (tx_idle),
    .o_wb    (tx_wb_req),
    .o_data  (tx_byte),
    .o_req   (tx_byte_req),
    .o_busy  (o_tx_busy)
  );

  rx_store #(.RX_BASE(RX_BASE)) u_store (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_start (i_start),
    .i_data  (rx_byte),
    .i_valid (rx_byte_valid),
    .i_wb    (rx_wb_rsp),
    .o_wb    (rx_wb_req),
    .o_count (o_rx_count)
  );

  uart_tx #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_data   (tx_byte),
    .i_req    (tx_byte_req),
    .o_serial (o_serial),
    .o_cts    (tx_cts),
    .o_idle   (tx_idle)
  );

  uart_rx #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_serial (i_serial),
    .o_data   (rx_byte),
    .o_valid  (rx_byte_valid)
  );

endmodule

// File: msg_ram.sv
module msg_ram (
  input  logic              clk,
  input  logic              rst_n,
  input  uart_pkg::wb_req_t i_wb,
  output uart_pkg::wb_rsp_t o_wb
);
  import uart_pkg::*;

  logic [7:0] mem [2**MSG_ADDR_W];
  logic       ack_q;
  logic [7:0] rdat_q;
  logic       req_new;

  // New request, not already being acked
  assign req_new = i_wb.cyc && i_wb.stb && !ack_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_new;
    end
  end

  // Write lands with the ack edge, read data valid with ack
  always_ff @(posedge clk) begin
    if (req_new) begin
      if (i_wb.we) begin
        mem[i_wb.adr] <= i_wb.dat;
      end
      rdat_q <= mem[i_wb.adr];
    end
  end

  assign o_wb.ack = ack_q;
  assign o_wb.dat = rdat_q;

endmodule

// File: wb_arbiter.sv
module wb_arbiter (
  input  logic              clk,
  input  logic              rst_n,
  input  uart_pkg::wb_req_t i_rx,
  input  uart_pkg::wb_req_t i_tx,
  input  uart_pkg::wb_req_t i_host,
  input  uart_pkg::wb_rsp_t i_slave,
  output uart_pkg::wb_rsp_t o_rx,
  output uart_pkg::wb_rsp_t o_tx,
  output uart_pkg::wb_rsp_t o_host,
  output uart_pkg::wb_req_t o_slave
);
  import uart_pkg::*;

  wb_master_e owner;
  wb_master_e grant;
  logic       owner_cyc;

  // Is the registered owner still in its cycle
  always_comb begin
    case (owner)
      MST_RX:   owner_cyc = i_rx.cyc;
      MST_TX:   owner_cyc = i_tx.cyc;
      MST_HOST: owner_cyc = i_host.cyc;
      default:  owner_cyc = 1'b0;
    endcase
  end

  // Keep owner while busy, else fixed priority
  always_comb begin
    if (owner_cyc) begin
      grant = owner;
    end else if (i_rx.cyc) begin
      grant = MST_RX;
    end else if (i_tx.cyc) begin
      grant = MST_TX;
    end else if (i_host.cyc) begin
      grant = MST_HOST;
    end else begin
      grant = MST_NONE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner <= MST_NONE;
    end else begin
      owner <= grant;
    end
  end

  // Request mux to the slave
  always_comb begin
    case (grant)
      MST_RX:   o_slave = i_rx;
      MST_TX:   o_slave = i_tx;
      MST_HOST: o_slave = i_host;
      default:  o_slave = '0;
    endcase
  end

  // Read data to all, ack to owner only
  always_comb begin
    o_rx       = i_slave;
    o_tx       = i_slave;
    o_host     = i_slave;
    o_rx.ack   = i_slave.ack && (grant == MST_RX);
    o_tx.ack   = i_slave.ack && (grant == MST_TX);
    o_host.ack = i_slave.ack && (grant == MST_HOST);
  end

endmodule

// File: rx_store.sv
module rx_store #(
  parameter int RX_BASE = 128
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_start,
  input  logic [7:0]        i_data,
  input  logic              i_valid,
  input  uart_pkg::wb_rsp_t i_wb,
  output uart_pkg::wb_req_t o_wb,
  output logic [7:0]        o_count
);
  import uart_pkg::*;

  logic       pend;
  logic [7:0] hold;

  // Write to the receive region at base plus count
  always_comb begin
    o_wb     = '0;
    o_wb.cyc = pend;
    o_wb.stb = pend;
    o_wb.we  = 1'b1;
    o_wb.adr = MSG_ADDR_W'(RX_BASE) + o_count[MSG_ADDR_W-1:0];
    o_wb.dat = hold;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend    <= 1'b0;
      o_count <= '0;
    end else begin
      if (i_valid) begin
        pend <= 1'b1;
      end else if (i_wb.ack) begin
        pend <= 1'b0;
      end
      // Restart of a message wins over a count step
      if (i_start) begin
        o_count <= '0;
      end else if (i_wb.ack) begin
        o_count <= (o_count == 8'd127) ? 8'd0 : o_count + 8'd1;
      end
    end
  end

  // Single byte holding register
  always_ff @(posedge clk) begin
    if (i_valid) begin
      hold <= i_data;
    end
  end

endmodule

// File: tx_fetch.sv
module tx_fetch (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_start,
  input  logic [7:0]        i_len,
  input  uart_pkg::wb_rsp_t i_wb,
  input  logic              i_cts,
  input  logic              i_idle,
  output uart_pkg::wb_req_t o_wb,
  output logic [7:0]        o_data,
  output logic              o_req,
  output logic              o_busy
);
  import uart_pkg::*;

  tx_fetch_state_e       state;
  logic [MSG_ADDR_W-1:0] addr;
  logic [7:0]            len_q;
  logic                  last;

  assign last = (addr == MSG_ADDR_W'(len_q - 8'd1));

  // Read-only master, cyc and stb for the whole read state
  always_comb begin
    o_wb     = '0;
    o_wb.cyc = (state == FETCH_READ);
    o_wb.stb = (state == FETCH_READ);
    o_wb.adr = addr;
  end

  assign o_req  = (state == FETCH_WAIT_CTS);
  assign o_busy = (state != FETCH_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= FETCH_IDLE;
      addr  <= '0;
      len_q <= '0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          // Start while busy never reaches here
          if (i_start) begin
            len_q <= i_len;
            addr  <= '0;
            state <= FETCH_READ;
          end
        end
        FETCH_READ: begin
          if (i_wb.ack) begin
            state <= FETCH_WAIT_CTS;
          end
        end
        FETCH_WAIT_CTS: begin
          // Byte taken by the transmitter
          if (i_cts) begin
            if (last) begin
              state <= FETCH_SEND;
            end else begin
              addr  <= addr + 1'b1;
              state <= FETCH_READ;
            end
          end
        end
        FETCH_SEND: begin
          // Drain the final frame
          if (i_idle) begin
            state <= FETCH_IDLE;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // Byte held for the transmitter
  always_ff @(posedge clk) begin
    if (state == FETCH_READ && i_wb.ack) begin
      o_data <= i_wb.dat;
    end
  end

endmodule

// File: uart_rx.sv
module uart_rx #(
  parameter int CYCLES_PER_BIT = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_serial,
  output logic [7:0] o_data,
  output logic       o_valid
);
  import uart_pkg::*;

  localparam int CYCLE_W = (CYCLES_PER_BIT > 1) ? $clog2(CYCLES_PER_BIT) : 1;
  localparam int HALF = (CYCLES_PER_BIT > 1) ? CYCLES_PER_BIT / 2 : 1;
  localparam logic [CYCLE_W-1:0] BIT_LAST  = CYCLE_W'(CYCLES_PER_BIT - 1);
  localparam logic [CYCLE_W-1:0] HALF_LAST = CYCLE_W'(HALF - 1);

  rx_state_e          state;
  logic [1:0]         sync;
  logic               line;
  logic               line_prev;
  logic [CYCLE_W-1:0] timer;
  logic [2:0]         bit_idx;
  logic [7:0]         shift;

  assign line   = sync[1];
  // Shift register holds the byte through the valid pulse
  assign o_data = shift;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync      <= 2'b11;
      line_prev <= 1'b1;
      state     <= RX_IDLE;
      timer     <= '0;
      bit_idx   <= '0;
      o_valid   <= 1'b0;
    end else begin
      sync      <= {sync[0], i_serial};
      line_prev <= line;
      o_valid   <= 1'b0;
      if (timer != '0) begin
        timer <= timer - 1'b1;
      end
      case (state)
        RX_IDLE: begin
          // Falling edge opens a frame
          if (line_prev && !line) begin
            state <= RX_START;
            timer <= HALF_LAST;
          end
        end
        RX_START: begin
          if (timer == '0) begin
            // Glitch if the line is back high at mid start bit
            state   <= line ? RX_IDLE : RX_DATA;
            timer   <= BIT_LAST;
            bit_idx <= '0;
          end
        end
        RX_DATA: begin
          if (timer == '0) begin
            timer   <= BIT_LAST;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (timer == '0) begin
            // Low stop bit drops the byte
            o_valid <= line;
            state   <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB first, sampled mid-bit
  always_ff @(posedge clk) begin
    if (state == RX_DATA && timer == '0) begin
      shift <= {line, shift[7:1]};
    end
  end

endmodule

// File: uart_tx.sv
module uart_tx #(
  parameter int CYCLES_PER_BIT = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] i_data,
  input  logic       i_req,
  output logic       o_serial,
  output logic       o_cts,
  output logic       o_idle
);

  // Start, 8 data, 1 stop, 7 extra stop bits
  localparam int EXTRA_STOP = 7;
  localparam int CURSOR_MAX = 9 + EXTRA_STOP;
  localparam int CURSOR_W = $clog2(CURSOR_MAX + 1);
  localparam int CYCLE_W = (CYCLES_PER_BIT > 1) ? $clog2(CYCLES_PER_BIT) : 1;
  localparam logic [CYCLE_W-1:0] CYCLE_MAX = CYCLE_W'(CYCLES_PER_BIT - 1);

  logic [CYCLE_W-1:0]  cycle;
  logic [CURSOR_W-1:0] cursor;
  logic [8:0]          buffer;
  logic                pend_valid;
  logic [7:0]          pend_data;
  logic                frame_done;

  // Last cycle of the last stop bit, or line idle
  assign frame_done = (cursor == '0) && (cycle == '0);
  assign o_serial   = buffer[0];
  // Open during extra stop bits; held byte waits for the full gap
  assign o_cts      = !pend_valid && (cursor < CURSOR_W'(EXTRA_STOP));
  assign o_idle     = frame_done && !pend_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle      <= '0;
      cursor     <= '0;
      buffer     <= '1;
      pend_valid <= 1'b0;
    end else if (frame_done && pend_valid) begin
      // Launch held byte, start bit in buffer[0]
      cycle      <= CYCLE_MAX;
      cursor     <= CURSOR_W'(CURSOR_MAX);
      buffer     <= {pend_data, 1'b0};
      pend_valid <= 1'b0;
    end else begin
      if (o_cts && i_req) begin
        pend_valid <= 1'b1;
      end
      if (cycle != '0) begin
        cycle <= cycle - 1'b1;
      end else if (cursor != '0) begin
        // Next bit, shift in stop level
        cycle  <= CYCLE_MAX;
        cursor <= cursor - 1'b1;
        buffer <= {1'b1, buffer[8:1]};
      end
    end
  end

  // Accepted byte
  always_ff @(posedge clk) begin
    if (o_cts && i_req) begin
      pend_data <= i_data;
    end
  end

endmodule

// File: uart_pkg.sv
package uart_pkg;

  // Message memory address width, 256 bytes
  localparam int MSG_ADDR_W = 8;

  // Wishbone classic request from a master
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [MSG_ADDR_W-1:0] adr;
    logic [7:0]            dat;
  } wb_req_t;

  // Wishbone classic response from the slave
  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

  // Current bus owner in the arbiter
  typedef enum logic [1:0] {
    MST_NONE = 2'd0,
    MST_RX   = 2'd1,
    MST_TX   = 2'd2,
    MST_HOST = 2'd3
  } wb_master_e;

  // Transmit fetch sequencing
  typedef enum logic [1:0] {
    FETCH_IDLE     = 2'd0,
    FETCH_READ     = 2'd1,
    FETCH_WAIT_CTS = 2'd2,
    FETCH_SEND     = 2'd3
  } tx_fetch_state_e;

  // Serial receiver frame position
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

endpackage
